// ==== rtl/dcache_pkg.sv ====
// dcache shared widths, data types and address/word helpers
package dcache_pkg;

    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 4;
    localparam int LINE_W     = WORD_W * LINE_WORDS;
    localparam int OFFSET_W   = 4;
    localparam int WSEL_W     = $clog2(LINE_WORDS);

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [LINE_W-1:0]   line_t;  // word 0 in the low bits
    typedef logic [WORD_W/8-1:0] strb_t;

    function automatic logic [WSEL_W-1:0] word_sel(input logic [ADDR_W-1:0] addr);
        return addr[OFFSET_W-1 -: WSEL_W];
    endfunction

    function automatic logic [ADDR_W-1:0] line_base(input logic [ADDR_W-1:0] addr);
        return {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    endfunction

    function automatic word_t line_word(input line_t line, input logic [WSEL_W-1:0] sel);
        return line[sel*WORD_W +: WORD_W];
    endfunction

    function automatic line_t put_word(input line_t line, input logic [WSEL_W-1:0] sel,
                                       input word_t w);
        line_t res;
        res = line;
        res[sel*WORD_W +: WORD_W] = w;
        return res;
    endfunction

    // new bytes where strobe set, old bytes elsewhere
    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                          input strb_t strb);
        word_t res;
        for (int b = 0; b < WORD_W/8; b++) begin
            res[b*8 +: 8] = strb[b] ? new_w[b*8 +: 8] : old_w[b*8 +: 8];
        end
        return res;
    endfunction

endpackage

// ==== rtl/cache_req_if.sv ====
// buffered cpu request passed from the request stage to the lookup stage
`timescale 1ns/1ns
interface cache_req_if;

    logic                          valid;
    logic                          wr;
    logic [dcache_pkg::ADDR_W-1:0] addr;
    dcache_pkg::strb_t             wstrb;
    dcache_pkg::word_t             wdata;
    logic                          advance;  // lookup done with current request, or empty

    modport stage (
        output valid,
        output wr,
        output addr,
        output wstrb,
        output wdata,
        input  advance
    );

    modport lookup (
        input  valid,
        input  wr,
        input  addr,
        input  wstrb,
        input  wdata,
        output advance
    );

endinterface

// ==== rtl/miss_if.sv ====
// victim writeback and refill exchange between lookup stage and miss controller
`timescale 1ns/1ns
interface miss_if;

    logic                          start;         // one cycle
    logic                          victim_dirty;
    logic [dcache_pkg::ADDR_W-1:0] victim_addr;
    dcache_pkg::line_t             victim_line;
    logic [dcache_pkg::ADDR_W-1:0] fill_addr;
    logic                          done;          // one cycle, fill_line valid
    dcache_pkg::line_t             fill_line;

    modport lookup (
        output start,
        output victim_dirty,
        output victim_addr,
        output victim_line,
        output fill_addr,
        input  done,
        input  fill_line
    );

    modport miss (
        input  start,
        input  victim_dirty,
        input  victim_addr,
        input  victim_line,
        input  fill_addr,
        output done,
        output fill_line
    );

endinterface

// ==== rtl/cache_way_ram.sv ====
// single cache way storage, one registered read port and one write port
`timescale 1ns/1ns
module cache_way_ram #(
    parameter int  SET_NUM = 16,
    parameter type entry_t = logic
) (
    input  logic                       clk_g,
    input  logic                       we,
    input  logic [$clog2(SET_NUM)-1:0] waddr,
    input  entry_t                     wdata,
    input  logic [$clog2(SET_NUM)-1:0] raddr,
    output entry_t                     rdata
);

    entry_t mem [SET_NUM];

    always_ff @(posedge clk_g) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read returns old contents on a same-cycle write
    always_ff @(posedge clk_g) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== rtl/dcache_req_stage.sv ====
// request buffer stage, takes cpu requests and drives the ram read index
`timescale 1ns/1ns
module dcache_req_stage #(
    parameter int SET_NUM = 16
) (
    input  logic                          clk_g,
    input  logic                          resetn,
    input  logic                          req,
    input  logic                          wr,
    input  logic [dcache_pkg::ADDR_W-1:0] addr,
    input  dcache_pkg::strb_t             wstrb,
    input  dcache_pkg::word_t             wdata,
    output logic                          addr_ok,
    output logic [$clog2(SET_NUM)-1:0]    rd_index,
    cache_req_if.stage                    rq
);

    localparam int INDEX_W = $clog2(SET_NUM);

    logic accept;

    assign addr_ok = req && rq.advance;
    assign accept  = addr_ok;

    // ram output must line up with what sits in the buffer next cycle
    assign rd_index = accept ? addr[dcache_pkg::OFFSET_W +: INDEX_W]
                             : rq.addr[dcache_pkg::OFFSET_W +: INDEX_W];

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            rq.valid <= 1'b0;
        end else if (rq.advance) begin
            rq.valid <= req;  // empties when nothing new arrives
        end
    end

    always_ff @(posedge clk_g) begin
        if (accept) begin
            rq.wr    <= wr;
            rq.addr  <= addr;
            rq.wstrb <= wstrb;
            rq.wdata <= wdata;
        end
    end

endmodule

// ==== rtl/dcache_lookup_stage.sv ====
// lookup stage with tag compare, word select, store merge, bypass and way state
`timescale 1ns/1ns
module dcache_lookup_stage #(
    parameter int ASSOC_NUM = 2,
    parameter int SET_NUM   = 16
) (
    input  logic                       clk_g,
    input  logic                       resetn,
    input  logic [$clog2(SET_NUM)-1:0] rd_index,
    cache_req_if.lookup                rq,
    miss_if.lookup                     mi,
    output logic                       data_ok,
    output dcache_pkg::word_t          rdata
);

    localparam int INDEX_W = $clog2(SET_NUM);
    localparam int TAG_W   = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::OFFSET_W;
    localparam int WAY_W   = $clog2(ASSOC_NUM);
    localparam int WSEL_W  = dcache_pkg::WSEL_W;

    typedef logic [TAG_W-1:0] tag_t;

    tag_t                   req_tag;
    logic [INDEX_W-1:0]     req_index;
    logic [WSEL_W-1:0]      req_word;
    tag_t                   tag_rdata [ASSOC_NUM];
    dcache_pkg::line_t      line_rdata [ASSOC_NUM];
    dcache_pkg::line_t      way_line [ASSOC_NUM];
    logic [ASSOC_NUM-1:0]   hit_vec, tag_we, data_we;
    logic [WAY_W-1:0]       hit_way, victim;
    logic                   active, hit, busy, answered;
    dcache_pkg::line_t      hit_line, store_line, fill_line_m, wr_line;
    dcache_pkg::word_t      hit_word, store_word, fill_word;

    logic [ASSOC_NUM-1:0]   valid_bits [SET_NUM];
    logic [ASSOC_NUM-1:0]   dirty_bits [SET_NUM];
    logic [WAY_W-1:0]       rr_ptr [SET_NUM];

    // last stored word, covers a ram read issued in the same cycle as its write
    logic                   byp_valid;
    logic [WAY_W-1:0]       byp_way;
    logic [INDEX_W-1:0]     byp_index;
    logic [WSEL_W-1:0]      byp_word;
    dcache_pkg::word_t      byp_data;

    assign req_tag   = rq.addr[dcache_pkg::ADDR_W-1 -: TAG_W];
    assign req_index = rq.addr[dcache_pkg::OFFSET_W +: INDEX_W];
    assign req_word  = dcache_pkg::word_sel(rq.addr);
    assign active    = rq.valid && !answered;  // answered miss waits one cycle to retire
    assign victim    = rr_ptr[req_index];

    always_comb begin
        hit_vec = '0;
        hit_way = '0;
        for (int w = 0; w < ASSOC_NUM; w++) begin
            way_line[w] = line_rdata[w];
            if (byp_valid && byp_way == WAY_W'(w) && byp_index == req_index) begin
                way_line[w] = dcache_pkg::put_word(line_rdata[w], byp_word, byp_data);
            end
            if (valid_bits[req_index][w] && tag_rdata[w] == req_tag) begin
                hit_vec[w] = 1'b1;
                hit_way    = WAY_W'(w);
            end
        end
    end

    assign hit        = active && |hit_vec;
    assign hit_line   = way_line[hit_way];
    assign hit_word   = dcache_pkg::line_word(hit_line, req_word);
    assign store_word = dcache_pkg::merge_bytes(hit_word, rq.wdata, rq.wstrb);
    assign store_line = dcache_pkg::put_word(hit_line, req_word, store_word);

    assign fill_word   = dcache_pkg::line_word(mi.fill_line, req_word);
    assign fill_line_m = rq.wr ? dcache_pkg::put_word(mi.fill_line, req_word,
                             dcache_pkg::merge_bytes(fill_word, rq.wdata, rq.wstrb))
                               : mi.fill_line;
    assign wr_line     = mi.done ? fill_line_m : store_line;

    assign rq.advance = !active || hit;
    assign data_ok    = hit || mi.done;
    assign rdata      = mi.done ? fill_word : hit_word;

    assign mi.start        = active && !hit && !busy;
    assign mi.victim_dirty = valid_bits[req_index][victim] && dirty_bits[req_index][victim];
    assign mi.victim_addr  = {tag_rdata[victim], req_index, {dcache_pkg::OFFSET_W{1'b0}}};
    assign mi.victim_line  = way_line[victim];
    assign mi.fill_addr    = dcache_pkg::line_base(rq.addr);

    for (genvar w = 0; w < ASSOC_NUM; w++) begin : g_way
        assign tag_we[w]  = mi.done && victim == WAY_W'(w);
        assign data_we[w] = tag_we[w] || (hit && rq.wr && hit_way == WAY_W'(w));

        cache_way_ram #(
            .SET_NUM (SET_NUM),
            .entry_t (tag_t)
        ) u_tag (
            .clk_g (clk_g),
            .we    (tag_we[w]),
            .waddr (req_index),
            .wdata (req_tag),
            .raddr (rd_index),
            .rdata (tag_rdata[w])
        );

        cache_way_ram #(
            .SET_NUM (SET_NUM),
            .entry_t (dcache_pkg::line_t)
        ) u_line (
            .clk_g (clk_g),
            .we    (data_we[w]),
            .waddr (req_index),
            .wdata (wr_line),
            .raddr (rd_index),
            .rdata (line_rdata[w])
        );
    end

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            busy      <= 1'b0;
            answered  <= 1'b0;
            byp_valid <= 1'b0;
            for (int s = 0; s < SET_NUM; s++) begin
                valid_bits[s] <= '0;
                dirty_bits[s] <= '0;
                rr_ptr[s]     <= '0;
            end
        end else begin
            answered <= mi.done;
            if (mi.start) begin
                busy <= 1'b1;
            end else if (mi.done) begin
                busy <= 1'b0;
            end
            if (mi.done) begin
                valid_bits[req_index][victim] <= 1'b1;
                dirty_bits[req_index][victim] <= rq.wr;
                rr_ptr[req_index]             <= victim + WAY_W'(1);
                byp_valid                     <= 1'b0;  // way now holds the refill
            end else if (hit && rq.wr) begin
                dirty_bits[req_index][hit_way] <= 1'b1;
                byp_valid                      <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_g) begin
        if (hit && rq.wr) begin
            byp_way   <= hit_way;
            byp_index <= req_index;
            byp_word  <= req_word;
            byp_data  <= store_word;
        end
    end

endmodule

// ==== rtl/dcache_miss_ctrl.sv ====
// miss FSM, dirty victim writeback then line refill over the memory port
`timescale 1ns/1ns
module dcache_miss_ctrl (
    input  logic                          clk_g,
    input  logic                          resetn,
    miss_if.miss                          mi,
    output logic                          rd_req,
    output logic [dcache_pkg::ADDR_W-1:0] rd_addr,
    input  logic                          rd_rdy,
    input  logic                          ret_valid,
    input  dcache_pkg::line_t             ret_data,
    output logic                          wr_req,
    output logic [dcache_pkg::ADDR_W-1:0] wr_addr,
    output dcache_pkg::line_t             wr_data,
    input  logic                          wr_rdy,
    input  logic                          wr_b_valid
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WR_REQ,
        S_WR_WAIT,
        S_RD_REQ,
        S_RD_WAIT
    } state_t;

    state_t state, state_next;

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            state <= S_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (mi.start) begin
                    state_next = mi.victim_dirty ? S_WR_REQ : S_RD_REQ;
                end
            end
            S_WR_REQ: begin
                if (wr_rdy) begin
                    state_next = S_WR_WAIT;
                end
            end
            S_WR_WAIT: begin
                if (wr_b_valid) begin
                    state_next = S_RD_REQ;
                end
            end
            S_RD_REQ: begin
                if (rd_rdy) begin
                    state_next = S_RD_WAIT;
                end
            end
            S_RD_WAIT: begin
                if (ret_valid) begin
                    state_next = S_IDLE;
                end
            end
            default: state_next = S_IDLE;
        endcase
    end

    // lookup holds victim and fill addresses stable until done
    assign wr_req  = state == S_WR_REQ;
    assign wr_addr = mi.victim_addr;
    assign wr_data = mi.victim_line;
    assign rd_req  = state == S_RD_REQ;
    assign rd_addr = mi.fill_addr;

    assign mi.done      = state == S_RD_WAIT && ret_valid;
    assign mi.fill_line = ret_data;

endmodule

// ==== rtl/dcache_top.sv ====
// data cache top, request stage, lookup stage and miss FSM on plain cpu and memory ports
`timescale 1ns/1ns
module dcache_top #(
    parameter int ASSOC_NUM = 2,
    parameter int SET_NUM   = 16
) (
    input  logic                          clk_g,
    input  logic                          resetn,
    input  logic                          req,
    input  logic                          wr,
    input  logic [dcache_pkg::ADDR_W-1:0] addr,
    input  dcache_pkg::strb_t             wstrb,
    input  dcache_pkg::word_t             wdata,
    output logic                          addr_ok,
    output logic                          data_ok,
    output dcache_pkg::word_t             rdata,
    output logic                          rd_req,
    output logic [dcache_pkg::ADDR_W-1:0] rd_addr,
    input  logic                          rd_rdy,
    input  logic                          ret_valid,
    input  dcache_pkg::line_t             ret_data,
    output logic                          wr_req,
    output logic [dcache_pkg::ADDR_W-1:0] wr_addr,
    output dcache_pkg::line_t             wr_data,
    input  logic                          wr_rdy,
    input  logic                          wr_b_valid
);

    logic [$clog2(SET_NUM)-1:0] rd_index;

    cache_req_if req_bus ();
    miss_if      miss_bus ();

    dcache_req_stage #(
        .SET_NUM (SET_NUM)
    ) u_req (
        .clk_g    (clk_g),
        .resetn   (resetn),
        .req      (req),
        .wr       (wr),
        .addr     (addr),
        .wstrb    (wstrb),
        .wdata    (wdata),
        .addr_ok  (addr_ok),
        .rd_index (rd_index),
        .rq       (req_bus)
    );

    dcache_lookup_stage #(
        .ASSOC_NUM (ASSOC_NUM),
        .SET_NUM   (SET_NUM)
    ) u_lookup (
        .clk_g    (clk_g),
        .resetn   (resetn),
        .rd_index (rd_index),
        .rq       (req_bus),
        .mi       (miss_bus),
        .data_ok  (data_ok),
        .rdata    (rdata)
    );

    dcache_miss_ctrl u_miss (
        .clk_g      (clk_g),
        .resetn     (resetn),
        .mi         (miss_bus),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_rdy     (rd_rdy),
        .ret_valid  (ret_valid),
        .ret_data   (ret_data),
        .wr_req     (wr_req),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_rdy     (wr_rdy),
        .wr_b_valid (wr_b_valid)
    );

endmodule

// ==== sim/tb_dcache.sv ====
// dcache testbench with memory model, directed and random traffic, reference check
`timescale 1ns/1ns
module tb_dcache;

    localparam int ASSOC   = 2;
    localparam int SETS    = 16;
    localparam int IDX_LSB = 4;
    localparam int TAG_LSB = IDX_LSB + $clog2(SETS);
    localparam int TMO     = 200;  // cycles per wait

    logic              clk_g = 1'b0;
    logic              resetn;
    logic              req, wr;
    logic [31:0]       addr;
    dcache_pkg::strb_t wstrb;
    dcache_pkg::word_t wdata;
    logic              addr_ok, data_ok;
    dcache_pkg::word_t rdata;
    logic              rd_req, rd_rdy, ret_valid;
    logic [31:0]       rd_addr;
    dcache_pkg::line_t ret_data;
    logic              wr_req, wr_rdy, wr_b_valid;
    logic [31:0]       wr_addr;
    dcache_pkg::line_t wr_data;

    dcache_pkg::word_t mem_model [1024];  // 4 KB window
    dcache_pkg::word_t ref_mem [1024];
    logic [32:0]       exp_q [$];         // {is_store, expected word}
    int                errors, checks, cmp_errors, cmp_checks;
    int                rd_count, wr_count, n_resp, resp_rd_count;
    logic [31:0]       last_wr_addr;
    logic              timed_out;
    string             cur_test;
    int                e0, c0;

    dcache_top #(
        .ASSOC_NUM (ASSOC),
        .SET_NUM   (SETS)
    ) UUT (.*);

    always #2 clk_g = ~clk_g;

    function automatic dcache_pkg::word_t fill_word(input int idx);
        return (32'(idx) * 32'h0001_0003) ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [31:0] mk_addr(input int tag, input int set, input int wd);
        return (32'(tag) << TAG_LSB) | (32'(set) << IDX_LSB) | (32'(wd) << 2);
    endfunction

    // expected word for a load, shadow memory holds every accepted store
    function automatic dcache_pkg::word_t ref_load(input logic [31:0] a);
        return ref_mem[a[11:2]];
    endfunction

    task automatic ref_store(input logic [31:0] a, input dcache_pkg::strb_t s,
                             input dcache_pkg::word_t d);
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                ref_mem[a[11:2]][b*8 +: 8] = d[b*8 +: 8];
            end
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        e0 = errors + cmp_errors;
        c0 = checks + cmp_checks;
    endtask

    task automatic end_test();
        $display("%s: %0d checks, %0d errors", cur_test,
                 checks + cmp_checks - c0, errors + cmp_errors - e0);
    endtask

    // holds req until addr_ok, returns at the accepting edge
    task automatic issue(input logic is_wr, input logic [31:0] a,
                         input dcache_pkg::strb_t s, input dcache_pkg::word_t d);
        int   t;
        logic got;
        @(negedge clk_g);
        req   = 1'b1;
        wr    = is_wr;
        addr  = a;
        wstrb = s;
        wdata = d;
        t     = 0;
        got   = 1'b0;
        while (!got && !timed_out) begin
            #1;
            if (addr_ok) begin
                got = 1'b1;
                if (is_wr) begin
                    exp_q.push_back({1'b1, 32'h0});
                    ref_store(a, s, d);
                end else begin
                    exp_q.push_back({1'b0, ref_load(a)});
                end
            end else if (t >= TMO) begin
                $display("%s: request to %h never accepted", cur_test, a);
                errors++;
                timed_out = 1'b1;
            end else begin
                t++;
                @(negedge clk_g);
            end
        end
        @(posedge clk_g);
    endtask

    task automatic drain();
        int t;
        @(negedge clk_g);
        req = 1'b0;
        t   = 0;
        while (exp_q.size() != 0 && t < TMO && !timed_out) begin
            @(negedge clk_g);
            t++;
        end
        if (exp_q.size() != 0 && !timed_out) begin
            $display("%s: %0d responses never arrived", cur_test, exp_q.size());
            errors++;
            timed_out = 1'b1;
        end
    endtask

    // memory side, random delays on both handshakes
    initial begin : mem_side
        int unsigned dly;
        logic [31:0] a;
        rd_rdy       = 1'b0;
        ret_valid    = 1'b0;
        ret_data     = '0;
        wr_rdy       = 1'b0;
        wr_b_valid   = 1'b0;
        rd_count     = 0;
        wr_count     = 0;
        last_wr_addr = '0;
        for (int i = 0; i < 1024; i++) begin
            mem_model[i] = fill_word(i);
        end
        forever begin
            @(negedge clk_g);
            if (resetn && rd_req) begin
                dly = $urandom % 4;
                repeat (dly) @(negedge clk_g);
                a      = rd_addr;
                rd_rdy = 1'b1;
                rd_count++;
                @(negedge clk_g);
                rd_rdy = 1'b0;
                dly    = $urandom % 4;
                repeat (dly) @(negedge clk_g);
                for (int k = 0; k < 4; k++) begin
                    ret_data[k*32 +: 32] = mem_model[{a[11:4], 2'(k)}];
                end
                ret_valid = 1'b1;
                @(negedge clk_g);
                ret_valid = 1'b0;
            end else if (resetn && wr_req) begin
                dly = $urandom % 4;
                repeat (dly) @(negedge clk_g);
                a = wr_addr;
                for (int k = 0; k < 4; k++) begin
                    mem_model[{a[11:4], 2'(k)}] = wr_data[k*32 +: 32];
                end
                last_wr_addr = a;
                wr_count++;
                wr_rdy = 1'b1;
                @(negedge clk_g);
                wr_rdy = 1'b0;
                dly    = $urandom % 4;
                repeat (dly) @(negedge clk_g);
                wr_b_valid = 1'b1;
                @(negedge clk_g);
                wr_b_valid = 1'b0;
            end
        end
    end

    initial begin : compare
        logic [32:0] e;
        cmp_errors    = 0;
        cmp_checks    = 0;
        n_resp        = 0;
        resp_rd_count = 0;
        forever begin
            @(negedge clk_g);
            #1;
            if (resetn === 1'b1 && data_ok) begin
                n_resp++;
                resp_rd_count = rd_count;
                if (exp_q.size() == 0) begin
                    $display("%s: data_ok with no request outstanding", cur_test);
                    cmp_errors++;
                end else begin
                    e = exp_q.pop_front();
                    if (!e[32]) begin
                        cmp_checks++;
                        if (rdata !== e[31:0]) begin
                            $display("[FAIL] %s expected %h actual %h", cur_test, e[31:0], rdata);
                            cmp_errors++;
                        end
                    end
                end
            end
        end
    end

    initial begin : main
        int          r0, w0, n0;
        logic [31:0] a;
        void'($urandom(94194));
        resetn    = 1'b0;
        req       = 1'b0;
        wr        = 1'b0;
        addr      = '0;
        wstrb     = '0;
        wdata     = '0;
        errors    = 0;
        checks    = 0;
        timed_out = 1'b0;
        cur_test  = "reset";
        for (int i = 0; i < 1024; i++) begin
            ref_mem[i] = fill_word(i);
        end
        repeat (16) @(posedge clk_g);
        @(negedge clk_g);
        resetn = 1'b1;

        begin_test("reset");
        repeat (20) begin
            @(negedge clk_g);
            #1;
            checks++;
            if (rd_req || wr_req || data_ok) begin
                $display("reset: memory request or data_ok seen while idle");
                errors++;
            end
        end
        end_test();

        begin_test("cold_load");
        r0 = rd_count;
        n0 = n_resp;
        issue(1'b0, mk_addr(2, 1, 1), '0, '0);
        drain();
        checks += 2;
        if (n_resp - n0 != 1) begin
            $display("[FAIL] cold_load data_ok count expected 1 actual %0d", n_resp - n0);
            errors++;
        end
        if (resp_rd_count != r0 + 1) begin
            $display("[FAIL] cold_load reads before data_ok expected %0d actual %0d",
                     r0 + 1, resp_rd_count);
            errors++;
        end
        end_test();

        begin_test("same_line");
        r0 = rd_count;
        issue(1'b0, mk_addr(2, 1, 3), '0, '0);
        drain();
        checks++;
        if (rd_count != r0) begin
            $display("[FAIL] same_line reads expected %0d actual %0d", r0, rd_count);
            errors++;
        end
        end_test();

        begin_test("bypass");
        a = mk_addr(2, 1, 2);
        issue(1'b1, a, 4'b0101, 32'hcafe_f00d);
        issue(1'b0, a, '0, '0);  // back to back with the store
        drain();
        end_test();

        begin_test("evict");
        w0 = wr_count;
        for (int i = 0; i <= ASSOC; i++) begin
            issue(1'b1, mk_addr(i, 5, 0), 4'hf, 32'hd0d0_0000 + 32'(i));
        end
        drain();
        checks += 2;
        if (wr_count == w0) begin
            $display("evict: no writeback seen for the dirty victim");
            errors++;
        end
        if (last_wr_addr != mk_addr(0, 5, 0)) begin
            $display("[FAIL] evict expected %h actual %h", mk_addr(0, 5, 0), last_wr_addr);
            errors++;
        end
        for (int i = 0; i <= ASSOC; i++) begin
            issue(1'b0, mk_addr(i, 5, 0), '0, '0);
        end
        drain();
        end_test();

        begin_test("random");
        for (int n = 0; n < 400; n++) begin
            a = mk_addr($urandom % 4, $urandom % 4, $urandom % 4);
            if ($urandom % 2 == 1) begin
                issue(1'b1, a, 4'($urandom), $urandom);
            end else begin
                issue(1'b0, a, '0, '0);
            end
        end
        drain();
        end_test();

        $display("tests 6, checks %0d, errors %0d", checks + cmp_checks, errors + cmp_errors);
        if (errors + cmp_errors == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
rtl/dcache_pkg.sv
rtl/cache_req_if.sv
rtl/miss_if.sv
rtl/cache_way_ram.sv
rtl/dcache_req_stage.sv
rtl/dcache_lookup_stage.sv
rtl/dcache_miss_ctrl.sv
rtl/dcache_top.sv
sim/tb_dcache.sv

// ==== run.sh ====
#!/bin/sh
# build and run the dcache simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module tb_dcache \
    --Mdir obj_dir -o sim_dcache

./obj_dir/sim_dcache > sim.log
cat sim.log

grep -q "Simulation passed" sim.log
echo "run.sh: pass"
